/* cim_macros.svh */
`ifndef CIM_MACROS_SVH
`define CIM_MACROS_SVH

// Data formats
`define CIM_ADC_BITS        12
`define CIM_COMP_BITS       16
`define CIM_COMP_FRAC       12
`define CIM_PARAM_BITS      12
`define CIM_PARAM_FRAC      10

// Model geometry, patch length equals embedding depth
`define CIM_EMB_DEPTH       8
`define CIM_NUM_PATCHES     4

// Memory sizes in words
`define CIM_INT_RES_DEPTH   128
`define CIM_PARAM_DEPTH     64

// Intermediate-result memory map
`define CIM_CLS_BASE        0
`define CIM_EEG_BASE        8
`define CIM_POS_EMB_BASE    40

// Parameter memory map
`define CIM_PARAM_CLS_BASE  0
// 40 words, one per token element
`define CIM_PARAM_POS_BASE  8

`endif

/* cim_fx_pkg.sv */
`default_nettype none

`include "cim_macros.svh"

package cim_fx_pkg;

    // Signed Q4.12 compute word
    typedef logic signed [`CIM_COMP_BITS-1:0] comp_fx_t;

    // Signed Q2.10 model parameter
    typedef logic signed [`CIM_PARAM_BITS-1:0] param_word_t;

    // Raw unsigned ADC sample
    typedef logic [`CIM_ADC_BITS-1:0] eeg_sample_t;

    // Memory addresses
    typedef logic [$clog2(`CIM_INT_RES_DEPTH)-1:0] int_res_addr_t;
    typedef logic [$clog2(`CIM_PARAM_DEPTH)-1:0] param_addr_t;

endpackage

`default_nettype wire

/* cim_ctrl_pkg.sv */
`default_nettype none

`include "cim_macros.svh"

package cim_ctrl_pkg;

    typedef enum logic [1:0] {
        IDLE,
        EEG_LOAD,
        INFERENCE
    } cim_state_t;

    typedef enum logic {
        CLASS_TOKEN_STEP,
        POS_EMB_STEP
    } inf_step_t;

    // One operation per cycle from sequencer to datapath
    typedef enum logic [1:0] {
        NONE,
        EEG_WRITE,
        CLASS_COPY,
        POS_ADD
    } dp_op_t;

    // Token row (class token plus patches) and column counters
    typedef logic [$clog2(`CIM_NUM_PATCHES+1)-1:0] row_cnt_t;
    typedef logic [$clog2(`CIM_EMB_DEPTH)-1:0] col_cnt_t;

endpackage

`default_nettype wire

/* cim_sram.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cim_macros.svh"

module cim_sram #(
    parameter type word_t = logic [`CIM_COMP_BITS-1:0],
    parameter int  DEPTH  = `CIM_INT_RES_DEPTH
) (
    input  wire logic                     clk,
    input  wire logic                     wr_en_i,
    input  wire logic [$clog2(DEPTH)-1:0] wr_addr_i,
    input  wire word_t                    wr_data_i,
    input  wire logic                     rd_en_i,
    input  wire logic [$clog2(DEPTH)-1:0] rd_addr_i,
    output word_t                         rd_data_o
);

    word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // Registered read, old data on a same-address write
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

`default_nettype wire

/* cim_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cim_macros.svh"

module cim_sequencer (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      start_eeg_load_i,
    input  wire logic                      new_eeg_data_i,
    input  wire logic                      new_sleep_epoch_i,
    input  wire logic                      host_rd_en_i,
    output cim_ctrl_pkg::dp_op_t           op_o,
    output cim_fx_pkg::int_res_addr_t      rd_addr_o,
    output cim_fx_pkg::int_res_addr_t      wr_addr_o,
    output cim_fx_pkg::param_addr_t        prm_addr_o,
    output logic                           host_rd_grant_o,
    output logic                           inference_complete_o,
    output logic                           host_rd_valid_o
);

    import cim_ctrl_pkg::*;
    import cim_fx_pkg::*;

    localparam col_cnt_t LAST_COL   = col_cnt_t'(`CIM_EMB_DEPTH - 1);
    localparam row_cnt_t LAST_PATCH = row_cnt_t'(`CIM_NUM_PATCHES - 1);
    localparam row_cnt_t LAST_ROW   = row_cnt_t'(`CIM_NUM_PATCHES);

    cim_state_t state_q;
    inf_step_t  step_q;
    row_cnt_t   row_q;
    col_cnt_t   col_q;
    logic       drain_q;

    // Row-major element index, depth is a power of two
    logic [$bits(row_cnt_t)+$bits(col_cnt_t)-1:0] idx;

    assign idx = {row_q, col_q};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q              <= IDLE;
            step_q               <= CLASS_TOKEN_STEP;
            row_q                <= '0;
            col_q                <= '0;
            drain_q              <= 1'b0;
            inference_complete_o <= 1'b0;
        end else begin
            inference_complete_o <= 1'b0;
            if (new_sleep_epoch_i && (state_q != INFERENCE)) begin
                // Loaded samples stay in memory
                state_q <= INFERENCE;
                step_q  <= CLASS_TOKEN_STEP;
                row_q   <= '0;
                col_q   <= '0;
                drain_q <= 1'b0;
            end else begin
                case (state_q)
                    IDLE: begin
                        if (start_eeg_load_i) begin
                            state_q <= EEG_LOAD;
                            row_q   <= '0;
                            col_q   <= '0;
                        end
                    end
                    EEG_LOAD: begin
                        if (new_eeg_data_i) begin
                            if (col_q == LAST_COL) begin
                                col_q <= '0;
                                row_q <= (row_q == LAST_PATCH) ? '0 : row_q + 1'b1;
                            end else begin
                                col_q <= col_q + 1'b1;
                            end
                        end
                    end
                    INFERENCE: begin
                        if (drain_q) begin
                            drain_q <= 1'b0;
                            if (step_q == CLASS_TOKEN_STEP) begin
                                step_q <= POS_EMB_STEP;
                            end else begin
                                // Last write has landed
                                state_q              <= IDLE;
                                step_q               <= CLASS_TOKEN_STEP;
                                inference_complete_o <= 1'b1;
                            end
                        end else if (col_q == LAST_COL) begin
                            col_q <= '0;
                            if (step_q == CLASS_TOKEN_STEP) begin
                                drain_q <= 1'b1;
                            end else if (row_q == LAST_ROW) begin
                                row_q   <= '0;
                                drain_q <= 1'b1;
                            end else begin
                                row_q <= row_q + 1'b1;
                            end
                        end else begin
                            col_q <= col_q + 1'b1;
                        end
                    end
                    default: begin
                        state_q <= IDLE;
                    end
                endcase
            end
        end
    end

    // Operation strobe for the current cycle
    always_comb begin
        op_o = NONE;
        case (state_q)
            EEG_LOAD: begin
                if (new_eeg_data_i) begin
                    op_o = EEG_WRITE;
                end
            end
            INFERENCE: begin
                if (!drain_q) begin
                    op_o = (step_q == CLASS_TOKEN_STEP) ? CLASS_COPY : POS_ADD;
                end
            end
            default: begin
                op_o = NONE;
            end
        endcase
    end

    // Row stays at zero during the class-token step
    always_comb begin
        rd_addr_o  = int_res_addr_t'(`CIM_CLS_BASE) + int_res_addr_t'(idx);
        prm_addr_o = param_addr_t'(`CIM_PARAM_POS_BASE) + param_addr_t'(idx);
        wr_addr_o  = int_res_addr_t'(`CIM_POS_EMB_BASE) + int_res_addr_t'(idx);
        if (state_q == EEG_LOAD) begin
            wr_addr_o = int_res_addr_t'(`CIM_EEG_BASE) + int_res_addr_t'(idx);
        end else if (step_q == CLASS_TOKEN_STEP) begin
            prm_addr_o = param_addr_t'(`CIM_PARAM_CLS_BASE) + param_addr_t'(idx);
            wr_addr_o  = int_res_addr_t'(`CIM_CLS_BASE) + int_res_addr_t'(idx);
        end
    end

    // Host owns the read port only while idle
    assign host_rd_grant_o = host_rd_en_i && (state_q == IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            host_rd_valid_o <= 1'b0;
        end else begin
            host_rd_valid_o <= host_rd_en_i;
        end
    end

endmodule

`default_nettype wire

/* cim_embed_datapath.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cim_macros.svh"

module cim_embed_datapath (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire cim_ctrl_pkg::dp_op_t      op_i,
    input  wire cim_fx_pkg::int_res_addr_t rd_addr_i,
    input  wire cim_fx_pkg::int_res_addr_t wr_addr_i,
    input  wire cim_fx_pkg::param_addr_t   prm_addr_i,
    input  wire cim_fx_pkg::eeg_sample_t   eeg_i,
    input  wire logic                      param_wr_en_i,
    input  wire cim_fx_pkg::param_addr_t   param_wr_addr_i,
    input  wire cim_fx_pkg::param_word_t   param_wr_data_i,
    input  wire logic                      host_rd_grant_i,
    input  wire cim_fx_pkg::int_res_addr_t host_rd_addr_i,
    input  wire cim_fx_pkg::param_word_t   prm_rd_data_i,
    input  wire cim_fx_pkg::comp_fx_t      ir_rd_data_i,
    output logic                           prm_wr_en_o,
    output cim_fx_pkg::param_addr_t        prm_wr_addr_o,
    output cim_fx_pkg::param_word_t        prm_wr_data_o,
    output logic                           prm_rd_en_o,
    output cim_fx_pkg::param_addr_t        prm_rd_addr_o,
    output logic                           ir_wr_en_o,
    output cim_fx_pkg::int_res_addr_t      ir_wr_addr_o,
    output cim_fx_pkg::comp_fx_t           ir_wr_data_o,
    output logic                           ir_rd_en_o,
    output cim_fx_pkg::int_res_addr_t      ir_rd_addr_o,
    output cim_fx_pkg::comp_fx_t           host_rd_data_o
);

    import cim_ctrl_pkg::*;
    import cim_fx_pkg::*;

    localparam int EEG_PAD   = `CIM_COMP_BITS - `CIM_ADC_BITS;
    localparam int PRM_SHIFT = `CIM_COMP_FRAC - `CIM_PARAM_FRAC;
    localparam int PRM_EXT   = `CIM_COMP_BITS - `CIM_PARAM_BITS - PRM_SHIFT;

    dp_op_t        op_q;
    int_res_addr_t wr_addr_q;
    comp_fx_t      eeg_norm;
    comp_fx_t      prm_cvt;
    comp_fx_t      emb_sum;

    // Sample MSB lands at weight 1/2, so the value is in [0, 1)
    assign eeg_norm = {{EEG_PAD{1'b0}}, eeg_i};

    // Q2.10 to Q4.12
    assign prm_cvt = {{PRM_EXT{prm_rd_data_i[`CIM_PARAM_BITS-1]}},
                      prm_rd_data_i,
                      {PRM_SHIFT{1'b0}}};

    assign emb_sum = ir_rd_data_i + prm_cvt;

    // Write stage trails the read stage by the memory latency
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            op_q <= NONE;
        end else begin
            op_q <= op_i;
        end
    end

    always_ff @(posedge clk) begin
        wr_addr_q <= wr_addr_i;
    end

    // Parameter memory, host writes go straight through
    assign prm_wr_en_o   = param_wr_en_i;
    assign prm_wr_addr_o = param_wr_addr_i;
    assign prm_wr_data_o = param_wr_data_i;
    assign prm_rd_en_o   = (op_i == CLASS_COPY) || (op_i == POS_ADD);
    assign prm_rd_addr_o = prm_addr_i;

    // Grant and POS_ADD never share a cycle
    assign ir_rd_en_o     = (op_i == POS_ADD) || host_rd_grant_i;
    assign ir_rd_addr_o   = host_rd_grant_i ? host_rd_addr_i : rd_addr_i;
    assign host_rd_data_o = ir_rd_data_i;

    always_comb begin
        ir_wr_en_o   = 1'b0;
        ir_wr_addr_o = wr_addr_q;
        ir_wr_data_o = emb_sum;
        if (op_i == EEG_WRITE) begin
            // Sample goes in at its own strobe edge
            ir_wr_en_o   = 1'b1;
            ir_wr_addr_o = wr_addr_i;
            ir_wr_data_o = eeg_norm;
        end else if (op_q == CLASS_COPY) begin
            ir_wr_en_o   = 1'b1;
            ir_wr_data_o = prm_cvt;
        end else if (op_q == POS_ADD) begin
            ir_wr_en_o   = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* cim_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cim_macros.svh"

module cim_top (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      start_eeg_load_i,
    input  wire logic                      new_eeg_data_i,
    input  wire cim_fx_pkg::eeg_sample_t   eeg_i,
    input  wire logic                      new_sleep_epoch_i,
    input  wire logic                      param_wr_en_i,
    input  wire cim_fx_pkg::param_addr_t   param_wr_addr_i,
    input  wire cim_fx_pkg::param_word_t   param_wr_data_i,
    input  wire logic                      host_rd_en_i,
    input  wire cim_fx_pkg::int_res_addr_t host_rd_addr_i,
    output cim_fx_pkg::comp_fx_t           host_rd_data_o,
    output logic                           host_rd_valid_o,
    output logic                           inference_complete_o
);

    import cim_ctrl_pkg::*;
    import cim_fx_pkg::*;

    // Sequencer to datapath
    dp_op_t        op;
    int_res_addr_t rd_addr;
    int_res_addr_t wr_addr;
    param_addr_t   prm_addr;
    logic          host_rd_grant;

    // Parameter memory ports
    logic          prm_wr_en;
    param_addr_t   prm_wr_addr;
    param_word_t   prm_wr_data;
    logic          prm_rd_en;
    param_addr_t   prm_rd_addr;
    param_word_t   prm_rd_data;

    // Intermediate-result memory ports
    logic          ir_wr_en;
    int_res_addr_t ir_wr_addr;
    comp_fx_t      ir_wr_data;
    logic          ir_rd_en;
    int_res_addr_t ir_rd_addr;
    comp_fx_t      ir_rd_data;

    cim_sequencer u_sequencer (
        .clk                  (clk),
        .rst_n                (rst_n),
        .start_eeg_load_i     (start_eeg_load_i),
        .new_eeg_data_i       (new_eeg_data_i),
        .new_sleep_epoch_i    (new_sleep_epoch_i),
        .host_rd_en_i         (host_rd_en_i),
        .op_o                 (op),
        .rd_addr_o            (rd_addr),
        .wr_addr_o            (wr_addr),
        .prm_addr_o           (prm_addr),
        .host_rd_grant_o      (host_rd_grant),
        .inference_complete_o (inference_complete_o),
        .host_rd_valid_o      (host_rd_valid_o)
    );

    cim_embed_datapath u_datapath (
        .clk             (clk),
        .rst_n           (rst_n),
        .op_i            (op),
        .rd_addr_i       (rd_addr),
        .wr_addr_i       (wr_addr),
        .prm_addr_i      (prm_addr),
        .eeg_i           (eeg_i),
        .param_wr_en_i   (param_wr_en_i),
        .param_wr_addr_i (param_wr_addr_i),
        .param_wr_data_i (param_wr_data_i),
        .host_rd_grant_i (host_rd_grant),
        .host_rd_addr_i  (host_rd_addr_i),
        .prm_rd_data_i   (prm_rd_data),
        .ir_rd_data_i    (ir_rd_data),
        .prm_wr_en_o     (prm_wr_en),
        .prm_wr_addr_o   (prm_wr_addr),
        .prm_wr_data_o   (prm_wr_data),
        .prm_rd_en_o     (prm_rd_en),
        .prm_rd_addr_o   (prm_rd_addr),
        .ir_wr_en_o      (ir_wr_en),
        .ir_wr_addr_o    (ir_wr_addr),
        .ir_wr_data_o    (ir_wr_data),
        .ir_rd_en_o      (ir_rd_en),
        .ir_rd_addr_o    (ir_rd_addr),
        .host_rd_data_o  (host_rd_data_o)
    );

    cim_sram #(
        .word_t (param_word_t),
        .DEPTH  (`CIM_PARAM_DEPTH)
    ) u_param_mem (
        .clk       (clk),
        .wr_en_i   (prm_wr_en),
        .wr_addr_i (prm_wr_addr),
        .wr_data_i (prm_wr_data),
        .rd_en_i   (prm_rd_en),
        .rd_addr_i (prm_rd_addr),
        .rd_data_o (prm_rd_data)
    );

    cim_sram #(
        .word_t (comp_fx_t),
        .DEPTH  (`CIM_INT_RES_DEPTH)
    ) u_int_res_mem (
        .clk       (clk),
        .wr_en_i   (ir_wr_en),
        .wr_addr_i (ir_wr_addr),
        .wr_data_i (ir_wr_data),
        .rd_en_i   (ir_rd_en),
        .rd_addr_i (ir_rd_addr),
        .rd_data_o (ir_rd_data)
    );

endmodule

`default_nettype wire

/* tb_cim_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cim_macros.svh"

module tb_cim_top;

    import cim_fx_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int ROW_WORDS    = (`CIM_NUM_PATCHES + 1) * `CIM_EMB_DEPTH;
    localparam int NUM_PARAMS   = `CIM_PARAM_POS_BASE + ROW_WORDS;
    localparam int NUM_SAMPLES  = `CIM_NUM_PATCHES * `CIM_EMB_DEPTH;
    localparam int NUM_WORDS    = `CIM_POS_EMB_BASE + ROW_WORDS;
    localparam int EPOCH_CYCLES = 51;
    localparam int NUM_EPOCHS   = 2;
    localparam int NUM_LOADS    = NUM_EPOCHS * NUM_PARAMS + NUM_SAMPLES;
    localparam int NUM_READS    = NUM_EPOCHS * NUM_WORDS;
    localparam int WATCHDOG_CYCLES = NUM_EPOCHS * 60 + (NUM_LOADS + NUM_READS) * 2 + 50;
    localparam logic [31:0] LFSR_SEED = 32'h2cb347c5;

    logic          clk;
    logic          rst_n;
    logic          start_eeg_load_i;
    logic          new_eeg_data_i;
    eeg_sample_t   eeg_i;
    logic          new_sleep_epoch_i;
    logic          param_wr_en_i;
    param_addr_t   param_wr_addr_i;
    param_word_t   param_wr_data_i;
    logic          host_rd_en_i;
    int_res_addr_t host_rd_addr_i;
    comp_fx_t      host_rd_data_o;
    logic          host_rd_valid_o;
    logic          inference_complete_o;

    logic [31:0]   lfsr;
    comp_fx_t      ir_model [`CIM_INT_RES_DEPTH];
    param_word_t   prm_model [`CIM_PARAM_DEPTH];

    cim_top u_cim_top (
        .clk                  (clk),
        .rst_n                (rst_n),
        .start_eeg_load_i     (start_eeg_load_i),
        .new_eeg_data_i       (new_eeg_data_i),
        .eeg_i                (eeg_i),
        .new_sleep_epoch_i    (new_sleep_epoch_i),
        .param_wr_en_i        (param_wr_en_i),
        .param_wr_addr_i      (param_wr_addr_i),
        .param_wr_data_i      (param_wr_data_i),
        .host_rd_en_i         (host_rd_en_i),
        .host_rd_addr_i       (host_rd_addr_i),
        .host_rd_data_o       (host_rd_data_o),
        .host_rd_valid_o      (host_rd_valid_o),
        .inference_complete_o (inference_complete_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the test sequence did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $fatal(1, "Watchdog expired");
    end

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[14:0], lfsr[0]};
        end
        return v;
    endfunction

    // Unsigned fraction s / 2^12 expressed in steps of 2^-12
    function automatic comp_fx_t sample_to_fx(input eeg_sample_t s);
        int scaled;
        scaled = int'(s) * (1 << `CIM_COMP_FRAC) / (1 << `CIM_ADC_BITS);
        return comp_fx_t'(scaled);
    endfunction

    function automatic comp_fx_t param_to_fx(input param_word_t p);
        int scaled;
        scaled = int'(p) * (1 << (`CIM_COMP_FRAC - `CIM_PARAM_FRAC));
        return comp_fx_t'(scaled);
    endfunction

    function automatic void model_inference();
        int_res_addr_t src;
        int_res_addr_t dst;
        param_addr_t   pa;
        for (int c = 0; c < `CIM_EMB_DEPTH; c++) begin
            dst = int_res_addr_t'(`CIM_CLS_BASE + c);
            pa  = param_addr_t'(`CIM_PARAM_CLS_BASE + c);
            ir_model[dst] = param_to_fx(prm_model[pa]);
        end
        // Element i is row i/8, column i%8
        for (int i = 0; i < ROW_WORDS; i++) begin
            src = int_res_addr_t'(`CIM_CLS_BASE + i);
            dst = int_res_addr_t'(`CIM_POS_EMB_BASE + i);
            pa  = param_addr_t'(`CIM_PARAM_POS_BASE + i);
            ir_model[dst] = comp_fx_t'(int'(ir_model[src]) + int'(param_to_fx(prm_model[pa])));
        end
    endfunction

    task automatic stop_on_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("RESULT: FAIL");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check_quiet(input int n);
        repeat (n) begin
            @(negedge clk);
            assert (inference_complete_o === 1'b0)
                else stop_on_error("completion strobe without a running inference");
            assert (host_rd_valid_o === 1'b0)
                else stop_on_error("read valid without a read strobe");
        end
    endtask

    task automatic write_params();
        param_addr_t a;
        for (int i = 0; i < NUM_PARAMS; i++) begin
            a               = param_addr_t'(i);
            param_wr_en_i   = 1'b1;
            param_wr_addr_i = a;
            param_wr_data_i = param_word_t'(take_bits(`CIM_PARAM_BITS));
            prm_model[a]    = param_wr_data_i;
            @(negedge clk);
        end
        param_wr_en_i = 1'b0;
    endtask

    task automatic load_eeg();
        int_res_addr_t a;
        start_eeg_load_i = 1'b1;
        @(negedge clk);
        start_eeg_load_i = 1'b0;
        for (int i = 0; i < NUM_SAMPLES; i++) begin
            // Random idle gap between samples
            if (take_bits(1) != 16'd0) begin
                @(negedge clk);
            end
            a              = int_res_addr_t'(`CIM_EEG_BASE + i);
            new_eeg_data_i = 1'b1;
            eeg_i          = eeg_sample_t'(take_bits(`CIM_ADC_BITS));
            ir_model[a]    = sample_to_fx(eeg_i);
            @(negedge clk);
            new_eeg_data_i = 1'b0;
        end
    endtask

    task automatic run_epoch(input logic noisy);
        int cycles;
        new_sleep_epoch_i = 1'b1;
        @(negedge clk);
        new_sleep_epoch_i = 1'b0;
        cycles = 1;
        while (!inference_complete_o && cycles < 2 * EPOCH_CYCLES) begin
            if (noisy) begin
                new_eeg_data_i = (take_bits(1) != 16'd0);
                eeg_i          = eeg_sample_t'(take_bits(`CIM_ADC_BITS));
            end
            @(negedge clk);
            cycles++;
        end
        new_eeg_data_i = 1'b0;
        assert (inference_complete_o === 1'b1)
            else stop_on_error("inference never signalled completion");
        assert (cycles <= EPOCH_CYCLES)
            else stop_on_error($sformatf("completion after %0d cycles, limit %0d",
                                         cycles, EPOCH_CYCLES));
        model_inference();
        check_quiet(4);
    endtask

    task automatic read_back();
        int_res_addr_t a;
        for (int i = 0; i < NUM_WORDS; i++) begin
            a              = int_res_addr_t'(i);
            host_rd_en_i   = 1'b1;
            host_rd_addr_i = a;
            @(negedge clk);
            host_rd_en_i = 1'b0;
            assert (host_rd_valid_o === 1'b1)
                else stop_on_error($sformatf("no read valid for address %0d", i));
            assert (host_rd_data_o === ir_model[a])
                else stop_on_error($sformatf("address %0d read %h, expected %h",
                                             i, host_rd_data_o, ir_model[a]));
            @(negedge clk);
            assert (host_rd_valid_o === 1'b0)
                else stop_on_error($sformatf("read valid held too long at address %0d", i));
        end
    endtask

    initial begin
        lfsr              = LFSR_SEED;
        rst_n             = 1'b0;
        start_eeg_load_i  = 1'b0;
        new_eeg_data_i    = 1'b0;
        eeg_i             = '0;
        new_sleep_epoch_i = 1'b0;
        param_wr_en_i     = 1'b0;
        param_wr_addr_i   = '0;
        param_wr_data_i   = '0;
        host_rd_en_i      = 1'b0;
        host_rd_addr_i    = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_quiet(8);

        // Epoch straight from the load state
        write_params();
        load_eeg();
        run_epoch(1'b0);
        read_back();

        // Old samples, new parameters, stray sample strobes
        write_params();
        run_epoch(1'b1);
        read_back();

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+.
cim_fx_pkg.sv
cim_ctrl_pkg.sv
cim_sram.sv
cim_sequencer.sv
cim_embed_datapath.sv
cim_top.sv
tb_cim_top.sv

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_cim_top -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "RESULT: PASS" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
